//--- Bender.yml
package:
  name: dispatch_top

dependencies: {}

sources:
  - common/rename_pkg.sv
  - common/dispatch_pkg.sv
  - rename/rename_map.sv
  - rename/free_list.sv
  - source/issue_queue.sv
  - source/reorder_buffer.sv
  - source/dispatch_top.sv
  - target: test
    files:
      - test/dispatch_tb.sv

//--- common/dispatch_pkg.sv
//****************************************
// issue and ROB sizing, RV32 opcodes used for classification
// depths must be powers of two, pointers wrap freely
//****************************************

package dispatch_pkg;

    localparam int iq_depth = 16;
    localparam int rob_depth = 16;

    typedef logic [$clog2(iq_depth)-1:0] iq_idx_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
    typedef logic [$clog2(rob_depth):0] rob_cnt_t;

    // major opcodes handled here
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;

    // M extension marker in funct7
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // ALU issue payload
    typedef struct packed {
        logic [31:0]          instr;
        logic [31:0]          pc;
        rename_pkg::phys_tag_t src1_tag;
        rename_pkg::phys_tag_t src2_tag;
        logic                 uses_src2;
        rename_pkg::phys_tag_t dest_tag;
        rob_idx_t             rob_idx;
    } alu_entry_t;

    // multiply/divide payload, no pc needed
    typedef struct packed {
        logic [31:0]          instr;
        rename_pkg::phys_tag_t src1_tag;
        rename_pkg::phys_tag_t src2_tag;
        logic                 uses_src2;
        rename_pkg::phys_tag_t dest_tag;
        rob_idx_t             rob_idx;
    } mul_entry_t;

endpackage

//--- common/rename_pkg.sv
//****************************************
// register naming for the rename stage
// arch x0 stays on tag 0, which never enters the free list
//****************************************

package rename_pkg;

    // architectural and physical register counts
    localparam int num_arch_regs = 32;
    localparam int num_phys_regs = 64;

    // tags outside the initial identity mapping
    localparam int num_free_regs = num_phys_regs - num_arch_regs;

    // architectural index, rs1/rs2/rd fields
    typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;

    // physical tag, also the scoreboard index
    typedef logic [$clog2(num_phys_regs)-1:0] phys_tag_t;

    // free list pointer and occupancy
    typedef logic [$clog2(num_free_regs)-1:0] free_ptr_t;
    typedef logic [$clog2(num_free_regs):0] free_cnt_t;

endpackage

//--- dispatch_top.f
common/rename_pkg.sv
common/dispatch_pkg.sv
rename/rename_map.sv
rename/free_list.sv
source/issue_queue.sv
source/reorder_buffer.sv
source/dispatch_top.sv
test/dispatch_tb.sv

//--- rename/free_list.sv
//****************************************
// holds 32..63 ascending after reset
// caller must not pop while empty
//****************************************
`timescale 1ns/100ps

module free_list (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc,
    output rename_pkg::phys_tag_t head_tag,
    input  logic                  release_valid,
    input  rename_pkg::phys_tag_t release_tag,
    output logic                  empty
);
    import rename_pkg::*;

    phys_tag_t slots [num_free_regs];
    free_ptr_t head, tail;
    free_cnt_t count;

    // next tag handed out, no read latency
    assign head_tag = slots[head];
    assign empty    = (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_free_regs; i++) begin
                slots[i] <= phys_tag_t'(num_arch_regs + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= free_cnt_t'(num_free_regs);
        end else begin
            if (alloc) begin
                head <= head + 1'b1;
            end
            // freed tags go behind the initial ones
            if (release_valid) begin
                slots[tail] <= release_tag;
                tail        <= tail + 1'b1;
            end
            if (alloc && !release_valid) begin
                count <= count - 1'b1;
            end else if (release_valid && !alloc) begin
                count <= count + 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) alloc |-> !empty
    ) else $error("free list popped while empty");

endmodule

//--- rename/rename_map.sv
//****************************************
// map and scoreboard update on the same edge as alloc
// wakeups seen by queues one cycle after the result edge
//****************************************
`timescale 1ns/100ps

module rename_map (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             alloc,
    input  rename_pkg::arch_reg_t            arch_rs1,
    input  rename_pkg::arch_reg_t            arch_rs2,
    input  rename_pkg::arch_reg_t            arch_rd,
    input  rename_pkg::phys_tag_t            new_tag,
    output rename_pkg::phys_tag_t            src1_tag,
    output rename_pkg::phys_tag_t            src2_tag,
    output rename_pkg::phys_tag_t            prev_tag,
    output logic [rename_pkg::num_phys_regs-1:0] ready_vec,
    input  logic                             wake_alu,
    input  rename_pkg::phys_tag_t            wake_alu_tag,
    input  logic                             wake_mul,
    input  rename_pkg::phys_tag_t            wake_mul_tag
);
    import rename_pkg::*;

    // arch to phys mapping
    phys_tag_t map_table [num_arch_regs];
    // one bit per phys tag, set when its value exists
    logic [num_phys_regs-1:0] scoreboard;

    // reads see the mapping before this edge's update
    assign src1_tag  = map_table[arch_rs1];
    assign src2_tag  = map_table[arch_rs2];
    assign prev_tag  = map_table[arch_rd];
    assign ready_vec = scoreboard;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // identity map, everything produced
            for (int i = 0; i < num_arch_regs; i++) begin
                map_table[i] <= phys_tag_t'(i);
            end
            scoreboard <= '1;
        end else begin
            if (alloc && (arch_rd != '0)) begin
                map_table[arch_rd] <= new_tag;
            end
            // tag 0 stays ready
            if (alloc && (new_tag != '0)) begin
                scoreboard[new_tag] <= 1'b0;
            end
            if (wake_alu) begin
                scoreboard[wake_alu_tag] <= 1'b1;
            end
            if (wake_mul) begin
                scoreboard[wake_mul_tag] <= 1'b1;
            end
        end
    end

endmodule

//--- source/dispatch_top.sv
//****************************************
// source may strobe only while instr_ready is high
// one multiply in flight, held until mul_result_valid
//****************************************
`timescale 1ns/100ps

module dispatch_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  logic [31:0]             instr,
    input  logic [31:0]             pc,
    output logic                    instr_ready,
    input  logic                    alu_ready,
    output logic                    alu_issue_valid,
    output dispatch_pkg::alu_entry_t alu_issue,
    output logic                    mul_issue_valid,
    output dispatch_pkg::mul_entry_t mul_issue,
    input  logic                    alu_result_valid,
    input  rename_pkg::phys_tag_t   alu_result_tag,
    input  dispatch_pkg::rob_idx_t  alu_result_rob,
    input  logic                    mul_result_valid,
    input  rename_pkg::phys_tag_t   mul_result_tag,
    input  dispatch_pkg::rob_idx_t  mul_result_rob,
    output logic                    commit_valid,
    output rename_pkg::arch_reg_t   commit_arch_rd,
    output rename_pkg::phys_tag_t   commit_phys_rd
);
    import rename_pkg::*;
    import dispatch_pkg::*;

    logic       [6:0] opcode;
    arch_reg_t        rs1, rs2, rd;
    logic             is_mul, uses_src2, writes_rd, accept;
    phys_tag_t        head_tag, dest_tag, src1_tag, src2_tag, prev_tag, release_tag;
    logic [num_phys_regs-1:0] ready_vec;
    rob_idx_t         rob_tail;
    logic             fl_empty, alu_full, mul_full, rob_full, release_valid;
    logic             running, mul_busy, mul_allow;
    alu_entry_t       alu_payload;
    mul_entry_t       mul_payload;

    // field extraction
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // M extension goes to the multiply queue, all else to the ALU
    assign is_mul    = (opcode == op_reg) && (instr[31:25] == funct7_muldiv);
    assign uses_src2 = (opcode == op_reg);
    // x0 destinations take no tag
    assign writes_rd = ((opcode == op_reg) || (opcode == op_imm)) && (rd != '0);
    assign dest_tag  = writes_rd ? head_tag : '0;
    assign accept    = instr_valid && instr_ready;

    // payloads share the renamed fields
    always_comb begin
        alu_payload.instr     = instr;
        alu_payload.pc        = pc;
        alu_payload.src1_tag  = src1_tag;
        alu_payload.src2_tag  = uses_src2 ? src2_tag : '0;
        alu_payload.uses_src2 = uses_src2;
        alu_payload.dest_tag  = dest_tag;
        alu_payload.rob_idx   = rob_tail;
        mul_payload.instr     = instr;
        mul_payload.src1_tag  = src1_tag;
        mul_payload.src2_tag  = src2_tag;
        mul_payload.uses_src2 = 1'b1;
        mul_payload.dest_tag  = dest_tag;
        mul_payload.rob_idx   = rob_tail;
    end

    // stall on any full structure, low until first edge after reset
    assign instr_ready = running && !fl_empty && !alu_full && !mul_full && !rob_full;

    // no new multiply while one is shown or outstanding
    assign mul_allow = !mul_busy && !mul_issue_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            mul_busy <= 1'b0;
        end else begin
            running  <= 1'b1;
            // result wins, a same-edge result belongs to the shown op
            mul_busy <= (mul_busy || mul_issue_valid) && !mul_result_valid;
        end
    end

    rename_map u_rename_map (
        .clk(clk), .rst_n(rst_n), .alloc(accept && writes_rd),
        .arch_rs1(rs1), .arch_rs2(rs2), .arch_rd(rd), .new_tag(dest_tag),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .prev_tag(prev_tag),
        .ready_vec(ready_vec),
        .wake_alu(alu_result_valid), .wake_alu_tag(alu_result_tag),
        .wake_mul(mul_result_valid), .wake_mul_tag(mul_result_tag)
    );

    free_list u_free_list (
        .clk(clk), .rst_n(rst_n), .alloc(accept && writes_rd), .head_tag(head_tag),
        .release_valid(release_valid), .release_tag(release_tag), .empty(fl_empty)
    );

    issue_queue #(.payload_t(alu_entry_t)) u_alu_iq (
        .clk(clk), .rst_n(rst_n), .insert(accept && !is_mul), .insert_entry(alu_payload),
        .ready_vec(ready_vec), .issue_allow(alu_ready),
        .issue_valid(alu_issue_valid), .issue_entry(alu_issue), .full(alu_full)
    );

    issue_queue #(.payload_t(mul_entry_t)) u_mul_iq (
        .clk(clk), .rst_n(rst_n), .insert(accept && is_mul), .insert_entry(mul_payload),
        .ready_vec(ready_vec), .issue_allow(mul_allow),
        .issue_valid(mul_issue_valid), .issue_entry(mul_issue), .full(mul_full)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst_n(rst_n), .alloc(accept), .arch_rd(writes_rd ? rd : '0),
        .new_tag(dest_tag), .prev_tag(prev_tag), .alloc_idx(rob_tail),
        .done_alu(alu_result_valid), .done_alu_idx(alu_result_rob),
        .done_mul(mul_result_valid), .done_mul_idx(mul_result_rob),
        .commit_valid(commit_valid), .commit_arch_rd(commit_arch_rd),
        .commit_phys_rd(commit_phys_rd),
        .release_valid(release_valid), .release_tag(release_tag), .full(rob_full)
    );

    // source must respect the stall level
    a_no_strobe_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n) instr_valid |-> instr_ready
    ) else $error("instr_valid while instr_ready low");

endmodule

//--- source/issue_queue.sv
//****************************************
// one payload type per instance, needs src/dest tag fields
// insert only while not full, issue registered one cycle later
//****************************************
`timescale 1ns/100ps

module issue_queue #(
    parameter type payload_t = dispatch_pkg::alu_entry_t
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             insert,
    input  payload_t                         insert_entry,
    input  logic [rename_pkg::num_phys_regs-1:0] ready_vec,
    input  logic                             issue_allow,
    output logic                             issue_valid,
    output payload_t                         issue_entry,
    output logic                             full
);
    import dispatch_pkg::*;

    payload_t            slots [iq_depth];
    logic [iq_depth-1:0] occupied;
    logic [iq_depth-1:0] ready;
    iq_idx_t             free_idx;
    iq_idx_t             sel_idx;
    logic                sel_found;
    logic                take;

    // wakeup against the live scoreboard
    always_comb begin
        for (int i = 0; i < iq_depth; i++) begin
            ready[i] = occupied[i] && ready_vec[slots[i].src1_tag]
                       && (!slots[i].uses_src2 || ready_vec[slots[i].src2_tag]);
        end
    end

    // lowest empty slot, downward scan keeps the last hit
    always_comb begin
        free_idx = '0;
        for (int i = iq_depth - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_idx = iq_idx_t'(i);
            end
        end
    end

    // highest ready slot wins
    always_comb begin
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int i = 0; i < iq_depth; i++) begin
            if (ready[i]) begin
                sel_idx   = iq_idx_t'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign full = &occupied;
    assign take = issue_allow && sel_found;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied    <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= take;
            // removal and insertion never hit the same slot
            if (take) begin
                occupied[sel_idx] <= 1'b0;
            end
            if (insert && !full) begin
                occupied[free_idx] <= 1'b1;
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (insert && !full) begin
            slots[free_idx] <= insert_entry;
        end
        if (take) begin
            issue_entry <= slots[sel_idx];
        end
    end

endmodule

//--- source/reorder_buffer.sv
//****************************************
// in-order retire, one per cycle, commit outputs registered
// arch rd 0 entries retire without freeing a tag
//****************************************
`timescale 1ns/100ps

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  rename_pkg::arch_reg_t  arch_rd,
    input  rename_pkg::phys_tag_t  new_tag,
    input  rename_pkg::phys_tag_t  prev_tag,
    output dispatch_pkg::rob_idx_t alloc_idx,
    input  logic                   done_alu,
    input  dispatch_pkg::rob_idx_t done_alu_idx,
    input  logic                   done_mul,
    input  dispatch_pkg::rob_idx_t done_mul_idx,
    output logic                   commit_valid,
    output rename_pkg::arch_reg_t  commit_arch_rd,
    output rename_pkg::phys_tag_t  commit_phys_rd,
    output logic                   release_valid,
    output rename_pkg::phys_tag_t  release_tag,
    output logic                   full
);
    import rename_pkg::*;
    import dispatch_pkg::*;

    arch_reg_t            rd_q   [rob_depth];
    phys_tag_t            dest_q [rob_depth];
    phys_tag_t            prev_q [rob_depth];
    logic [rob_depth-1:0] busy;
    logic [rob_depth-1:0] done;
    rob_idx_t             head, tail;
    rob_cnt_t             count;
    logic                 retire;

    // head leaves once its result is back
    assign retire        = busy[head] && done[head];
    assign alloc_idx     = tail;
    assign full          = (count == rob_cnt_t'(rob_depth));
    assign release_valid = commit_valid && (commit_arch_rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= '0;
            done         <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (retire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (done_alu) begin
                done[done_alu_idx] <= 1'b1;
            end
            if (done_mul) begin
                done[done_mul_idx] <= 1'b1;
            end
            // tail slot is free, no clash with done writes
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (alloc && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !alloc) begin
                count <= count - 1'b1;
            end
        end
    end

    // per-entry payload and commit data
    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail]   <= arch_rd;
            dest_q[tail] <= new_tag;
            prev_q[tail] <= prev_tag;
        end
        if (retire) begin
            commit_arch_rd <= rd_q[head];
            commit_phys_rd <= dest_q[head];
            release_tag    <= prev_q[head];
        end
    end

endmodule

//--- test/dispatch_tb.sv
//****************************************
// random table of ALU/multiply rows, rename model kept here
// responders answer issues after 1..6 cycles
//****************************************
`timescale 1ns/100ps

module dispatch_tb;
    import rename_pkg::*;
    import dispatch_pkg::*;

    localparam int num_rows   = 56;
    localparam int clk_period = 4;

    logic       clk, rst_n, instr_valid, instr_ready, alu_ready;
    logic [31:0] instr, pc;
    logic       alu_issue_valid, mul_issue_valid, commit_valid;
    alu_entry_t alu_issue;
    mul_entry_t mul_issue;
    logic       alu_result_valid, mul_result_valid;
    phys_tag_t  alu_result_tag, mul_result_tag, commit_phys_rd;
    rob_idx_t   alu_result_rob, mul_result_rob;
    arch_reg_t  commit_arch_rd;

    // stimulus table, class 0 reg ALU, 1 imm ALU, 2 multiply
    logic [31:0] tbl_instr [num_rows];
    int          tbl_class [num_rows];
    arch_reg_t   tbl_rs1 [num_rows];
    arch_reg_t   tbl_rs2 [num_rows];
    arch_reg_t   tbl_rd [num_rows];
    // expected tags, filled when the row is dispatched
    phys_tag_t   exp_src1 [num_rows];
    phys_tag_t   exp_src2 [num_rows];
    phys_tag_t   exp_dest [num_rows];
    phys_tag_t   exp_prev [num_rows];
    logic        issued [num_rows];

    // reference map, free list and produced tags
    phys_tag_t                map_model [num_arch_regs];
    phys_tag_t                free_model [$];
    logic [num_phys_regs-1:0] produced;

    // ALU results waiting for their due cycle
    phys_tag_t alu_wait_tag [$];
    rob_idx_t  alu_wait_rob [$];
    int        alu_wait_due [$];
    logic      mul_busy_tb;
    phys_tag_t mul_tag_q;
    rob_idx_t  mul_rob_q;
    int        mul_due;

    logic [31:0] rng;
    int          cycle, row, commit_row;
    logic        saw_rob_full;

    dispatch_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // end the run if progress stops
    initial begin
        #(num_rows * 40 * clk_period);
        report_failure("timeout, commits stopped before the table finished");
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_alu(input string name, input alu_entry_t want, input alu_entry_t got);
        if (got !== want) begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic compare_mul(input string name, input mul_entry_t want, input mul_entry_t got);
        if (got !== want) begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic compare_commit(input string name, input arch_reg_t want_rd,
                                  input phys_tag_t want_tag, input arch_reg_t got_rd,
                                  input phys_tag_t got_tag);
        if ((got_rd !== want_rd) || (got_tag !== want_tag)) begin
            report_failure($sformatf("[FAIL] %s expected x%0d/p%0d actual x%0d/p%0d",
                                     name, want_rd, want_tag, got_rd, got_tag));
        end
    endtask

    // small register range so rows depend on each other
    task automatic build_table();
        logic [6:0] f7;
        for (int i = 0; i < num_rows; i++) begin
            rng          = xorshift(rng);
            tbl_class[i] = int'(rng[7:0] % 3);
            tbl_rd[i]    = arch_reg_t'(rng[10:8]);
            tbl_rs1[i]   = arch_reg_t'(rng[14:12]);
            tbl_rs2[i]   = arch_reg_t'(rng[18:16]);
            issued[i]    = 1'b0;
            f7 = (tbl_class[i] == 2) ? 7'b0000001 : 7'b0000000;
            if (tbl_class[i] == 1) begin
                // addi, immediate from the upper random bits
                tbl_instr[i] = {rng[31:20], tbl_rs1[i], 3'b000, tbl_rd[i], 7'b0010011};
                tbl_rs2[i]   = '0;
            end else begin
                tbl_instr[i] = {f7, tbl_rs2[i], tbl_rs1[i], 3'b000, tbl_rd[i], 7'b0110011};
            end
        end
    endtask

    // identity map, 32..63 free, all tags produced
    task automatic reset_model();
        for (int i = 0; i < num_arch_regs; i++) begin
            map_model[i] = phys_tag_t'(i);
        end
        for (int i = num_arch_regs; i < num_phys_regs; i++) begin
            free_model.push_back(phys_tag_t'(i));
        end
        produced = '1;
    endtask

    function automatic alu_entry_t expected_alu(input int r);
        alu_entry_t e;
        e.instr     = tbl_instr[r];
        e.pc        = r * 4;
        e.src1_tag  = exp_src1[r];
        e.src2_tag  = exp_src2[r];
        e.uses_src2 = (tbl_class[r] == 0);
        e.dest_tag  = exp_dest[r];
        e.rob_idx   = rob_idx_t'(r);
        return e;
    endfunction

    function automatic mul_entry_t expected_mul(input int r);
        mul_entry_t e;
        e.instr     = tbl_instr[r];
        e.src1_tag  = exp_src1[r];
        e.src2_tag  = exp_src2[r];
        e.uses_src2 = 1'b1;
        e.dest_tag  = exp_dest[r];
        e.rob_idx   = rob_idx_t'(r);
        return e;
    endfunction

    function automatic logic sources_produced(input int r);
        return produced[exp_src1[r]] && ((tbl_class[r] == 1) || produced[exp_src2[r]]);
    endfunction

    // in-flight multiply row that owns this ROB slot
    function automatic int mul_row_for(input rob_idx_t idx);
        for (int i = commit_row; i < row; i++) begin
            if ((rob_idx_t'(i) == idx) && (tbl_class[i] == 2) && !issued[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // alu_ready still holds the value of the selecting edge
    task automatic alu_issue_seen();
        int r;
        if (alu_issue_valid) begin
            r = int'(alu_issue.pc >> 2);
            if ((r >= row) || (tbl_class[r] == 2) || issued[r]) begin
                report_failure("ALU issued an entry that is unknown or already issued");
            end
            if (!alu_ready) begin
                report_failure("ALU issued while alu_ready was low at the selecting edge");
            end
            if (!sources_produced(r)) begin
                report_failure($sformatf("ALU row %0d issued before its sources were ready", r));
            end
            compare_alu($sformatf("alu issue row %0d", r), expected_alu(r), alu_issue);
            issued[r] = 1'b1;
            rng       = xorshift(rng);
            alu_wait_tag.push_back(alu_issue.dest_tag);
            alu_wait_rob.push_back(alu_issue.rob_idx);
            alu_wait_due.push_back(cycle + 1 + int'(rng % 6));
        end
    endtask

    task automatic mul_issue_seen();
        int r;
        if (mul_issue_valid) begin
            r = mul_row_for(mul_issue.rob_idx);
            if (r < 0) begin
                report_failure("multiply issued with no matching row in flight");
            end
            if (mul_busy_tb) begin
                report_failure("second multiply issued while one was outstanding");
            end
            if (!sources_produced(r)) begin
                report_failure($sformatf("mul row %0d issued before its sources were ready", r));
            end
            compare_mul($sformatf("mul issue row %0d", r), expected_mul(r), mul_issue);
            issued[r]   = 1'b1;
            mul_busy_tb = 1'b1;
            mul_tag_q   = mul_issue.dest_tag;
            mul_rob_q   = mul_issue.rob_idx;
            rng         = xorshift(rng);
            mul_due     = cycle + 1 + int'(rng % 6);
        end
    endtask

    // in-order retire, old mapping goes back to the model
    task automatic commit_seen();
        if (commit_valid) begin
            if ((commit_row >= row) || !issued[commit_row]) begin
                report_failure("commit for a row that was not dispatched and issued");
            end
            compare_commit($sformatf("commit row %0d", commit_row), tbl_rd[commit_row],
                           exp_dest[commit_row], commit_arch_rd, commit_phys_rd);
            if (tbl_rd[commit_row] != '0) begin
                free_model.push_back(exp_prev[commit_row]);
            end
            commit_row++;
        end
    endtask

    // strobes just sampled by the DUT
    task automatic record_results();
        if (alu_result_valid) begin
            produced[alu_result_tag] = 1'b1;
        end
        if (mul_result_valid) begin
            produced[mul_result_tag] = 1'b1;
            mul_busy_tb              = 1'b0;
        end
    endtask

    task automatic send_results();
        alu_result_valid = 1'b0;
        mul_result_valid = 1'b0;
        if ((alu_wait_due.size() > 0) && (alu_wait_due[0] <= cycle)) begin
            alu_result_valid = 1'b1;
            alu_result_tag   = alu_wait_tag.pop_front();
            alu_result_rob   = alu_wait_rob.pop_front();
            void'(alu_wait_due.pop_front());
        end
        if (mul_busy_tb && (cycle >= mul_due)) begin
            mul_result_valid = 1'b1;
            mul_result_tag   = mul_tag_q;
            mul_result_rob   = mul_rob_q;
        end
    endtask

    // rename through the model, same order as the DUT
    task automatic rename_row(input int r);
        exp_src1[r] = map_model[tbl_rs1[r]];
        exp_src2[r] = (tbl_class[r] == 1) ? phys_tag_t'(0) : map_model[tbl_rs2[r]];
        exp_prev[r] = map_model[tbl_rd[r]];
        if (tbl_rd[r] != '0) begin
            exp_dest[r]           = free_model.pop_front();
            map_model[tbl_rd[r]]  = exp_dest[r];
            produced[exp_dest[r]] = 1'b0;
        end else begin
            exp_dest[r] = '0;
        end
    endtask

    task automatic offer_instr();
        instr_valid = 1'b0;
        if (row - commit_row == rob_depth) begin
            saw_rob_full = 1'b1;
            if (instr_ready) begin
                report_failure("instr_ready high while the ROB holds 16 entries");
            end
        end
        if ((row < num_rows) && instr_ready) begin
            rename_row(row);
            instr_valid = 1'b1;
            instr       = tbl_instr[row];
            pc          = row * 4;
            row++;
        end
    endtask

    initial begin
        rng              = 32'ha12b;
        rst_n            = 1'b0;
        instr_valid      = 1'b0;
        instr            = '0;
        pc               = '0;
        alu_ready        = 1'b0;
        alu_result_valid = 1'b0;
        alu_result_tag   = '0;
        alu_result_rob   = '0;
        mul_result_valid = 1'b0;
        mul_result_tag   = '0;
        mul_result_rob   = '0;
        cycle            = 0;
        row              = 0;
        commit_row       = 0;
        saw_rob_full     = 1'b0;
        mul_busy_tb      = 1'b0;
        mul_due          = 0;
        build_table();
        reset_model();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        while (commit_row < num_rows) begin
            @(posedge clk);
            #1;
            cycle++;
            // checks first, then the edge's results, then new inputs
            alu_issue_seen();
            mul_issue_seen();
            commit_seen();
            record_results();
            send_results();
            rng       = xorshift(rng);
            alu_ready = (rng % 4) != 0;
            offer_instr();
        end
        if (!saw_rob_full) begin
            report_failure("ROB never held 16 entries, stall was not exercised");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
